/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --assert --timing --top-module core_top -f verilog.f

sim:
	verilator --binary --assert --timing --top-module tb_core -f verilog.f
	@out=$$(./obj_dir/Vtb_core); echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* rtl/core_pkg.sv */
package core_pkg;

    // rv32i base opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    // stores are not executed; only their immediate layout is known.
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word viewed per format.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    // fwd_ex means the producer sits in execute and is picked up there.
    typedef enum logic [1:0] {
        FWD_RF, FWD_EX, FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic [31:0] pc;
        inst_u       inst;
    } issue_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic        wen;
        alu_op_e     alu_op;
        br_op_e      br_op;
        logic        use_imm;
        logic        use_pc;
        fwd_sel_e    fwd1;
        fwd_sel_e    fwd2;
    } dec_ex_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] wdata;
        logic        is_branch;
        logic        taken;
        logic [31:0] target;
    } ex_res_t;

    typedef ex_res_t retire_t;

endpackage

/* rtl/core_top.sv */
`timescale 1ns/10ps

module core_top import core_pkg::*; (
    input  logic    clk,
    input  logic    id_reg_rst,
    input  logic    in_valid,
    input  issue_t  in,
    output logic    retire_valid,
    output retire_t retire
);

    logic        dec_valid;
    dec_ex_t     dec;
    logic        ex_valid;
    ex_res_t     ex_res;
    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    // retire record doubles as the older forwarding source.
    decode_stage decode_stage_i (
        .clk(clk),
        .id_reg_rst(id_reg_rst),
        .in_valid(in_valid),
        .in(in),
        .ex_valid(ex_valid),
        .ex_res(ex_res),
        .wb_valid(retire_valid),
        .wb_res(retire),
        .wb_we(wb_we),
        .wb_addr(wb_addr),
        .wb_data(wb_data),
        .dec_valid(dec_valid),
        .dec(dec)
    );

    execute_stage execute_stage_i (
        .clk(clk),
        .id_reg_rst(id_reg_rst),
        .dec_valid(dec_valid),
        .dec(dec),
        .ex_valid(ex_valid),
        .ex_res(ex_res)
    );

    result_stage result_stage_i (
        .clk(clk),
        .id_reg_rst(id_reg_rst),
        .ex_valid(ex_valid),
        .ex_res(ex_res),
        .retire_valid(retire_valid),
        .retire(retire),
        .wb_we(wb_we),
        .wb_addr(wb_addr),
        .wb_data(wb_data)
    );

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        id_reg_rst,
    input  logic        in_valid,
    input  issue_t      in,
    input  logic        ex_valid,
    input  ex_res_t     ex_res,
    input  logic        wb_valid,
    input  retire_t     wb_res,
    input  logic        wb_we,
    input  logic [4:0]  wb_addr,
    input  logic [31:0] wb_data,
    output logic        dec_valid,
    output dec_ex_t     dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rs1_a;
    logic [4:0]  rs2_a;
    logic [4:0]  rd_a;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [31:0] imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    fwd_sel_e    fwd1;
    fwd_sel_e    fwd2;
    alu_op_e     alu_op;
    br_op_e      br_op;
    logic        use_imm;
    logic        use_pc;
    logic        writes;
    logic        legal;
    dec_ex_t     dec_next;

    assign opcode = in.inst.r_fmt.opcode;
    assign funct3 = in.inst.r_fmt.funct3;
    assign funct7 = in.inst.r_fmt.funct7;
    assign rs1_a  = in.inst.r_fmt.rs1;
    assign rs2_a  = in.inst.r_fmt.rs2;
    assign rd_a   = in.inst.r_fmt.rd;

    reg_file reg_file_i (
        .clk(clk), .id_reg_rst(id_reg_rst),
        .ra1(rs1_a), .ra2(rs2_a), .wa(wb_addr),
        .we(wb_we), .wd(wb_data),
        .rd1(rd1), .rd2(rd2)
    );

    imm_gen imm_gen_i (
        .inst(in.inst),
        .imm(imm)
    );

    // sub only exists in the register form.
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // youngest producer wins.
    function automatic fwd_sel_e resolve(input logic [4:0] ra, input logic [31:0] rf_val,
                                         output logic [31:0] val);
        val = rf_val;
        if (dec_valid && dec.wen && dec.rd == ra) begin
            return FWD_EX;
        end else if (ex_valid && ex_res.wen && ex_res.rd == ra) begin
            val = ex_res.wdata;
            return FWD_WB;
        end else if (wb_valid && wb_res.wen && wb_res.rd == ra) begin
            val = wb_res.wdata;
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        alu_op  = ALU_ADD;
        br_op   = BR_NONE;
        use_imm = 1'b0;
        use_pc  = 1'b0;
        writes  = 1'b1;
        legal   = 1'b1;
        case (opcode)
            OPC_OP:     alu_op = alu_decode(funct3, funct7[5], 1'b1);
            OPC_OP_IMM: begin
                alu_op  = alu_decode(funct3, funct7[5], 1'b0);
                use_imm = 1'b1;
            end
            OPC_LUI: begin
                alu_op  = ALU_PASS_B;
                use_imm = 1'b1;
            end
            OPC_AUIPC: begin
                use_imm = 1'b1;
                use_pc  = 1'b1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                case (funct3)
                    3'b000:  br_op = BR_BEQ;
                    3'b001:  br_op = BR_BNE;
                    3'b100:  br_op = BR_BLT;
                    3'b101:  br_op = BR_BGE;
                    3'b110:  br_op = BR_BLTU;
                    3'b111:  br_op = BR_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL:  br_op = BR_JAL;
            OPC_JALR: br_op = BR_JALR;
            default: begin
                writes = 1'b0;
                legal  = 1'b0;
            end
        endcase
    end

    always_comb begin
        fwd1 = resolve(rs1_a, rd1, rs1_val);
        fwd2 = resolve(rs2_a, rd2, rs2_val);
    end

    always_comb begin
        dec_next.pc      = in.pc;
        dec_next.rs1_val = rs1_val;
        dec_next.rs2_val = rs2_val;
        dec_next.imm     = imm;
        dec_next.rd      = rd_a;
        dec_next.wen     = writes && rd_a != 5'd0;
        dec_next.alu_op  = alu_op;
        dec_next.br_op   = br_op;
        dec_next.use_imm = use_imm;
        dec_next.use_pc  = use_pc;
        dec_next.fwd1    = fwd1;
        dec_next.fwd2    = fwd2;
    end

    always_ff @(posedge clk) begin
        if (id_reg_rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec <= dec_next;
        end
    end

    a_legal_issue: assert property (@(posedge clk) disable iff (id_reg_rst)
        in_valid |-> legal);

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage import core_pkg::*; (
    input  logic    clk,
    input  logic    id_reg_rst,
    input  logic    dec_valid,
    input  dec_ex_t dec,
    output logic    ex_valid,
    output ex_res_t ex_res
);

    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_res;
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        taken;
    logic        is_jump;
    ex_res_t     res_next;

    // producer one slot ahead has just landed in ex_res.
    assign src1 = (dec.fwd1 == FWD_EX) ? ex_res.wdata : dec.rs1_val;
    assign src2 = (dec.fwd2 == FWD_EX) ? ex_res.wdata : dec.rs2_val;

    assign alu_a = dec.use_pc ? dec.pc : src1;
    assign alu_b = dec.use_imm ? dec.imm : src2;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = alu_a + alu_b;
            ALU_SUB:  alu_res = alu_a - alu_b;
            ALU_SLL:  alu_res = alu_a << alu_b[4:0];
            ALU_SLT:  alu_res = {31'd0, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_res = {31'd0, alu_a < alu_b};
            ALU_XOR:  alu_res = alu_a ^ alu_b;
            ALU_SRL:  alu_res = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_res = $unsigned($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_res = alu_a | alu_b;
            ALU_AND:  alu_res = alu_a & alu_b;
            default:  alu_res = alu_b;
        endcase
    end

    assign eq  = src1 == src2;
    assign lt  = $signed(src1) < $signed(src2);
    assign ltu = src1 < src2;

    assign is_jump = dec.br_op == BR_JAL || dec.br_op == BR_JALR;

    always_comb begin
        case (dec.br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = !ltu;
            BR_JAL, BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        res_next.pc        = dec.pc;
        res_next.rd        = dec.rd;
        res_next.wen       = dec.wen;
        res_next.wdata     = is_jump ? dec.pc + 32'd4 : alu_res;
        res_next.is_branch = dec.br_op != BR_NONE;
        res_next.taken     = taken;
        if (dec.br_op == BR_NONE) res_next.target = 32'd0;
        else if (dec.br_op == BR_JALR) res_next.target = (src1 + dec.imm) & ~32'd1;
        else res_next.target = dec.pc + dec.imm;
    end

    always_ff @(posedge clk) begin
        if (id_reg_rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_res <= res_next;
        end
    end

    a_target_aligned: assert property (@(posedge clk) disable iff (id_reg_rst)
        (dec_valid && res_next.taken) |=> ex_res.target[0] == 1'b0);

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen import core_pkg::*; (
    input  inst_u       inst,
    output logic [31:0] imm
);

    logic [6:0] opcode;

    assign opcode = inst.r_fmt.opcode;

    always_comb begin
        case (opcode)
            OPC_OP_IMM, OPC_JALR: begin
                imm = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
            end
            OPC_STORE: begin
                imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                       inst.s_fmt.imm_4_0};
            end
            OPC_BRANCH: begin
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            end
            OPC_LUI, OPC_AUIPC: begin
                imm = {inst.u_fmt.imm_31_12, 12'd0};
            end
            OPC_JAL: begin
                imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            end
            // register-register has no immediate.
            default: begin
                imm = 32'd0;
            end
        endcase
    end

endmodule

/* rtl/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        id_reg_rst,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    // x0 has no storage.
    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (id_reg_rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // write-through for the instruction retiring this cycle.
    always_comb begin
        if (ra1 == 5'd0) rd1 = 32'd0;
        else if (we && wa == ra1) rd1 = wd;
        else rd1 = regs[ra1];

        if (ra2 == 5'd0) rd2 = 32'd0;
        else if (we && wa == ra2) rd2 = wd;
        else rd2 = regs[ra2];
    end

endmodule

/* rtl/result_stage.sv */
`timescale 1ns/10ps

module result_stage import core_pkg::*; (
    input  logic        clk,
    input  logic        id_reg_rst,
    input  logic        ex_valid,
    input  ex_res_t     ex_res,
    output logic        retire_valid,
    output retire_t     retire,
    output logic        wb_we,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data
);

    always_ff @(posedge clk) begin
        if (id_reg_rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            retire <= ex_res;
        end
    end

    // write lands on the edge the record leaves.
    assign wb_we   = retire_valid && retire.wen;
    assign wb_addr = retire.rd;
    assign wb_data = retire.wdata;

    // decode drops wen for rd of zero.
    a_no_x0_write: assert property (@(posedge clk) disable iff (id_reg_rst)
        wb_we |-> wb_addr != 5'd0);

endmodule

/* test/tb_core.sv */
`timescale 1ns/10ps

module tb_core import core_pkg::*; ();

    localparam int NUM_INSTS    = 400;
    localparam int RESET_CYCLES = 10;
    localparam int MARGIN       = 40;

    logic    clk;
    logic    id_reg_rst;
    logic    in_valid;
    issue_t  in;
    logic    retire_valid;
    retire_t retire;

    int          seed;
    int          cycle = 0;
    logic [31:0] model_regs [32];
    retire_t     exp_q [$];
    int          due_q [$];

    core_top core_top_i (
        .clk(clk),
        .id_reg_rst(id_reg_rst),
        .in_valid(in_valid),
        .in(in),
        .retire_valid(retire_valid),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        $display("error %s expected %h actual %h", name, exp, act);
        fail_run();
    endtask

    task automatic check_retire(input retire_t exp, input retire_t act);
        if (act.pc !== exp.pc) report_value("retire.pc", exp.pc, act.pc);
        if (act.rd !== exp.rd) report_value("retire.rd", 32'(exp.rd), 32'(act.rd));
        if (act.wen !== exp.wen) report_value("retire.wen", 32'(exp.wen), 32'(act.wen));
        // wdata only matters when it is written back.
        if (exp.wen && act.wdata !== exp.wdata) begin
            report_value("retire.wdata", exp.wdata, act.wdata);
        end
    endtask

    task automatic check_branch(input retire_t exp, input retire_t act);
        if (act.is_branch !== exp.is_branch) begin
            report_value("retire.is_branch", 32'(exp.is_branch), 32'(act.is_branch));
        end
        if (act.taken !== exp.taken) begin
            report_value("retire.taken", 32'(exp.taken), 32'(act.taken));
        end
        if (exp.is_branch && act.target !== exp.target) begin
            report_value("retire.target", exp.target, act.target);
        end
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // mostly x0..x7 so that dependencies are frequent.
    function automatic logic [4:0] pick_reg();
        if (rnd(8) == 0) begin
            return 5'(rnd(32));
        end
        return 5'(rnd(8));
    endfunction

    function automatic logic [2:0] pick_branch_f3();
        case (rnd(6))
            0:       return 3'b000;
            1:       return 3'b001;
            2:       return 3'b100;
            3:       return 3'b101;
            4:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // builds one instruction, runs it on the model and strobes it in.
    task automatic issue_one(input logic [31:0] pc);
        int          pick;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  shamt;
        logic [11:0] imm12;
        logic [12:0] imm13;
        logic [19:0] imm20;
        logic [20:0] imm21;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        retire_t     exp;

        pick  = rnd(16);
        rd    = pick_reg();
        rs1   = pick_reg();
        rs2   = pick_reg();
        a     = model_regs[rs1];
        b     = model_regs[rs2];
        imm12 = 12'(rand32());
        imm20 = 20'(rand32());
        shamt = 5'(rnd(32));
        exp   = '0;
        exp.pc = pc;

        if (pick < 5) begin
            f3   = 3'(rnd(8));
            alt  = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rnd(2)) : 1'b0;
            word = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP};
            exp.wdata = alu_model(f3, alt, a, b);
            exp.wen   = rd != 5'd0;
        end else if (pick < 10) begin
            f3  = 3'(rnd(8));
            alt = 1'b0;
            if (f3 == 3'd1) begin
                imm12 = {7'h00, shamt};
            end else if (f3 == 3'd5) begin
                alt   = 1'(rnd(2));
                imm12 = {alt ? 7'h20 : 7'h00, shamt};
            end
            imm  = {{20{imm12[11]}}, imm12};
            word = {imm12, rs1, f3, rd, OPC_OP_IMM};
            exp.wdata = alu_model(f3, alt, a, imm);
            exp.wen   = rd != 5'd0;
        end else if (pick == 10) begin
            word = {imm20, rd, OPC_LUI};
            exp.wdata = {imm20, 12'd0};
            exp.wen   = rd != 5'd0;
        end else if (pick == 11) begin
            word = {imm20, rd, OPC_AUIPC};
            exp.wdata = pc + {imm20, 12'd0};
            exp.wen   = rd != 5'd0;
        end else if (pick < 14) begin
            f3    = pick_branch_f3();
            imm13 = {imm12, 1'b0};
            imm   = {{19{imm13[12]}}, imm13};
            word  = {imm13[12], imm13[10:5], rs2, rs1, f3, imm13[4:1], imm13[11], OPC_BRANCH};
            exp.is_branch = 1'b1;
            exp.taken     = branch_model(f3, a, b);
            exp.target    = pc + imm;
        end else if (pick == 14) begin
            imm21 = {imm20, 1'b0};
            imm   = {{11{imm21[20]}}, imm21};
            word  = {imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, OPC_JAL};
            exp.wdata     = pc + 32'd4;
            exp.wen       = rd != 5'd0;
            exp.is_branch = 1'b1;
            exp.taken     = 1'b1;
            exp.target    = pc + imm;
        end else begin
            imm  = {{20{imm12[11]}}, imm12};
            word = {imm12, rs1, 3'b000, rd, OPC_JALR};
            exp.wdata     = pc + 32'd4;
            exp.wen       = rd != 5'd0;
            exp.is_branch = 1'b1;
            exp.taken     = 1'b1;
            exp.target    = (a + imm) & ~32'd1;
        end

        exp.rd = word[11:7];
        if (exp.wen) begin
            model_regs[exp.rd] = exp.wdata;
        end

        in_valid = 1'b1;
        in       = {pc, word};
        exp_q.push_back(exp);
        due_q.push_back(cycle + 3);
    endtask

    initial begin : stimulus
        logic [31:0] pc;
        int          gap;

        seed       = 89;
        id_reg_rst = 1'b1;
        in_valid   = 1'b0;
        in         = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        id_reg_rst = 1'b0;
        pc = rand32() & 32'hffff_fffc;

        // nothing may retire in these idle cycles.
        repeat (3) @(posedge clk);

        for (int n = 0; n < NUM_INSTS; n++) begin
            @(posedge clk);
            #1;
            issue_one(pc);
            pc  = pc + 32'd4;
            gap = rnd(4);
            gap = (gap < 2) ? 0 : gap - 1;
            repeat (gap) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        in       = '0;

        while (exp_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        $display("SIMULATION PASSED");
        $finish;
    end

    // retire is sampled half a cycle after the edge that launched it.
    always @(negedge clk) begin : monitor
        retire_t exp;
        int      due;

        if (!id_reg_rst && retire_valid !== 1'b0) begin
            if (retire_valid !== 1'b1) begin
                $display("retire_valid is unknown after reset");
                fail_run();
            end
            if (exp_q.size() == 0) begin
                $display("unexpected retirement with no instruction outstanding");
                fail_run();
            end
            exp = exp_q.pop_front();
            due = due_q.pop_front();
            if (cycle != due) begin
                $display("instruction at pc %h retired in cycle %0d instead of cycle %0d",
                         exp.pc, cycle, due);
                fail_run();
            end
            check_retire(exp, retire);
            check_branch(exp, retire);
        end
    end

    initial begin : watchdog
        repeat (NUM_INSTS * 3 + RESET_CYCLES + MARGIN) @(posedge clk);
        $display("timeout with %0d instructions still outstanding", exp_q.size());
        fail_run();
    end

endmodule

/* verilog.f */
rtl/core_pkg.sv
rtl/reg_file.sv
rtl/imm_gen.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/core_top.sv
test/tb_core.sv
